/* compile.f */
+incdir+verilog
verilog/scsiDmaPkg.sv
verilog/scsiSm.sv
verilog/dmaFifo.sv
verilog/scsiDmaTop.sv
testbench/scsiDma_assertions.sv
testbench/scsiDmaChecker.sv
testbench/scsiDmaTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= scsiDmaTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)

/* testbench/scsiDmaTb.sv */
// Testbench for the SCSI DMA engine with a behavioral SCSI chip model
// The DUT has no register address bus, so the chip model takes its address from the table
// Inputs change 2 ns after the rising BCLK edge, every wait gives up after WaitLimit cycles
module scsiDmaTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WaitLimit = 2000;
    localparam logic [1:0] OpWrite = 2'd0;
    localparam logic [1:0] OpRead = 2'd1;
    localparam logic [1:0] OpDmaIn = 2'd2;
    localparam logic [1:0] OpDmaOut = 2'd3;

    // One stimulus row, count is in longwords
    typedef struct packed {
        logic [1:0] op;
        logic [2:0] addr;
        logic [4:0] count;
        logic [7:0] data;
        logic       stall;
        logic       cpuMid;
    } stimRow_t;

    logic BCLK;
    logic CRESET_;
    logic cpuReq_i, cpuRw_i, dsack_o, dreqN_i, dmaDir_i;
    logic scsiCs_o, scsiRe_o, scsiWe_o, dack_o;
    logic memPush_i, memPop_i, fifoFull_o, fifoEmpty_o;
    logic [7:0] cpuData_i, cpuData_o, scsiData_i, scsiData_o;
    logic [31:0] memData_i, memData_o;

    // Chip model state
    logic [2:0] chipAddr;
    logic [7:0] regFile [8];
    logic reSeen, weSeen;
    int srcIdx, srcLimit, sinkIdx, sinkLimit;

    int timeouts;
    int errCount;
    int total;
    logic endOfTest;
    stimRow_t stim [9];

    scsiDmaTop u_dut (.*);

    scsiDmaChecker u_chk (
        .BCLK(BCLK), .CRESET_(CRESET_), .cpuReq_i(cpuReq_i), .cpuRw_i(cpuRw_i),
        .cpuData_i(cpuData_i), .cpuDataOut_i(cpuData_o), .dsack_i(dsack_o),
        .scsiData_i(scsiData_i), .scsiDataOut_i(scsiData_o), .scsiCs_i(scsiCs_o),
        .scsiRe_i(scsiRe_o), .scsiWe_i(scsiWe_o), .dack_i(dack_o), .dmaDir_i(dmaDir_i),
        .memPush_i(memPush_i), .memData_i(memData_i), .memPop_i(memPop_i),
        .memDataOut_i(memData_o), .fifoFull_i(fifoFull_o), .fifoEmpty_i(fifoEmpty_o),
        .chipAddr_i(chipAddr), .endOfTest_i(endOfTest), .errCount_o(errCount)
    );

    initial begin
        BCLK = 1'b0;
        forever #10 BCLK = ~BCLK;
    end

    // Chip model, answers strobes and paces DMA with DREQ
    always @(posedge BCLK) begin
        #2;
        if (scsiRe_o && !reSeen) begin
            if (scsiCs_o) begin
                scsiData_i = regFile[chipAddr];
            end else if (dack_o) begin
                scsiData_i = 8'($urandom);
                srcIdx++;
            end
        end
        if (scsiWe_o && !weSeen) begin
            if (scsiCs_o) begin
                regFile[chipAddr] = scsiData_o;
            end else if (dack_o) begin
                sinkIdx++;
            end
        end
        reSeen = scsiRe_o;
        weSeen = scsiWe_o;
        // Random gaps in DREQ, released once the byte budget is used up
        dreqN_i = !((dmaDir_i ? (sinkIdx < sinkLimit) : (srcIdx < srcLimit)) &&
                    ($urandom % 4 != 0));
    end

    task automatic tick();
        @(posedge BCLK);
        #2;
    endtask

    task automatic noteTimeout(input string what);
        timeouts++;
        $display("Timeout while waiting for %s", what);
    endtask

    task automatic cpuAccess(input logic rw, input logic [2:0] addr, input logic [7:0] data);
        int t;
        chipAddr = addr;
        cpuRw_i = rw;
        cpuData_i = data;
        cpuReq_i = 1'b1;
        t = 0;
        do begin
            tick();
            t++;
        end while (!dsack_o && t < WaitLimit);
        if (!dsack_o) noteTimeout("dsack_o");
        cpuReq_i = 1'b0;
        // Synchronized request has to fall before the next access
        repeat (4) tick();
    endtask

    task automatic dmaIn(input stimRow_t row);
        int t;
        int first;
        dmaDir_i = 1'b0;
        first = srcLimit;
        srcLimit = srcLimit + 4 * int'(row.count);
        if (row.cpuMid) begin
            t = 0;
            while (srcIdx < first + 4 && t < WaitLimit) begin
                tick();
                t++;
            end
            if (t >= WaitLimit) noteTimeout("the first DMA longword");
            cpuAccess(1'b1, row.addr, row.data);
        end
        if (row.stall) begin
            t = 0;
            while (!fifoFull_o && t < WaitLimit) begin
                tick();
                t++;
            end
            if (t >= WaitLimit) noteTimeout("a full FIFO");
            repeat (20) tick();
        end
        for (int n = 0; n < int'(row.count); n++) begin
            t = 0;
            while (fifoEmpty_o && t < WaitLimit) begin
                tick();
                t++;
            end
            if (t >= WaitLimit) noteTimeout("a longword to pop");
            memPop_i = 1'b1;
            tick();
            memPop_i = 1'b0;
        end
    endtask

    task automatic dmaOut(input stimRow_t row);
        int t;
        dmaDir_i = 1'b1;
        sinkLimit = sinkLimit + 4 * int'(row.count);
        // DREQ already asserted against an empty FIFO
        if (row.stall) repeat (20) tick();
        for (int n = 0; n < int'(row.count); n++) begin
            t = 0;
            while (fifoFull_o && t < WaitLimit) begin
                tick();
                t++;
            end
            if (t >= WaitLimit) noteTimeout("room in the FIFO");
            memData_i = $urandom;
            memPush_i = 1'b1;
            tick();
            memPush_i = 1'b0;
        end
        t = 0;
        while ((sinkIdx < sinkLimit || !fifoEmpty_o) && t < WaitLimit) begin
            tick();
            t++;
        end
        if (t >= WaitLimit) noteTimeout("the chip to take all DMA bytes");
    endtask

    initial begin
        void'($urandom(32'h8410_c440));
        CRESET_ = 1'b0;
        cpuReq_i = 1'b0;
        cpuRw_i = 1'b0;
        cpuData_i = 8'h00;
        dreqN_i = 1'b1;
        dmaDir_i = 1'b0;
        scsiData_i = 8'h00;
        memPush_i = 1'b0;
        memPop_i = 1'b0;
        memData_i = 32'h0;
        chipAddr = 3'd0;
        reSeen = 1'b0;
        weSeen = 1'b0;
        srcIdx = 0;
        srcLimit = 0;
        sinkIdx = 0;
        sinkLimit = 0;
        timeouts = 0;
        endOfTest = 1'b0;
        // op, addr, count, data, stall, cpuMid
        stim[0] = '{OpWrite, 3'd1, 5'd0, 8'h5a, 1'b0, 1'b0};
        stim[1] = '{OpRead, 3'd1, 5'd0, 8'h00, 1'b0, 1'b0};
        stim[2] = '{OpWrite, 3'd6, 5'd0, 8'hc3, 1'b0, 1'b0};
        stim[3] = '{OpRead, 3'd6, 5'd0, 8'h00, 1'b0, 1'b0};
        stim[4] = '{OpDmaIn, 3'd0, 5'd3, 8'h00, 1'b0, 1'b0};
        stim[5] = '{OpDmaOut, 3'd0, 5'd2, 8'h00, 1'b0, 1'b0};
        stim[6] = '{OpDmaIn, 3'd0, 5'd10, 8'h00, 1'b1, 1'b0};
        stim[7] = '{OpDmaOut, 3'd0, 5'd9, 8'h00, 1'b1, 1'b0};
        stim[8] = '{OpDmaIn, 3'd6, 5'd4, 8'h00, 1'b0, 1'b1};
        repeat (10) @(posedge BCLK);
        #2;
        CRESET_ = 1'b1;
        repeat (4) tick();
        for (int i = 0; i < 9 && timeouts == 0; i++) begin
            case (stim[i].op)
                OpWrite: cpuAccess(1'b0, stim[i].addr, stim[i].data);
                OpRead: cpuAccess(1'b1, stim[i].addr, stim[i].data);
                OpDmaIn: dmaIn(stim[i]);
                default: dmaOut(stim[i]);
            endcase
        end
        endOfTest = 1'b1;
        repeat (3) tick();
        total = errCount + timeouts + u_dut.u_scsiSm.u_strobeChecks.failCount;
        $display("Errors: checker %0d, timeouts %0d, assertions %0d", errCount, timeouts,
                 u_dut.u_scsiSm.u_strobeChecks.failCount);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/scsiDmaChecker.sv */
// Reference model and comparisons for the SCSI DMA engine
// Read data of a register is only known once the CPU has written it
// FIFO flags are compared only while DACK is low
`include "scsiDma_config.svh"

module scsiDmaChecker (
    input  logic        BCLK,
    input  logic        CRESET_,
    input  logic        cpuReq_i,
    input  logic        cpuRw_i,
    input  logic [7:0]  cpuData_i,
    input  logic [7:0]  cpuDataOut_i,
    input  logic        dsack_i,
    input  logic [7:0]  scsiData_i,
    input  logic [7:0]  scsiDataOut_i,
    input  logic        scsiCs_i,
    input  logic        scsiRe_i,
    input  logic        scsiWe_i,
    input  logic        dack_i,
    input  logic        dmaDir_i,
    input  logic        memPush_i,
    input  logic [31:0] memData_i,
    input  logic        memPop_i,
    input  logic [31:0] memDataOut_i,
    input  logic        fifoFull_i,
    input  logic        fifoEmpty_i,
    input  logic [2:0]  chipAddr_i,
    input  logic        endOfTest_i,
    output int          errCount_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int StrobeLen = `SCSI_DMA_STROBE_CYCLES;
    localparam int Depth = 1 << `SCSI_DMA_FIFO_DEPTH_LOG2;

    logic [7:0] regModel [8];
    logic regValid [8];
    // Bytes read from the chip, longwords waiting for a pop, bytes due at the chip
    logic [7:0] inBytes [$];
    logic [31:0] inWords [$];
    logic [7:0] outBytes [$];
    logic [31:0] word;
    int rdRun, wrRun, dsackCount, errs;
    // Expected number of longwords held in the FIFO
    int occ;
    logic expFull;
    logic expEmpty;
    logic resetChecked, prevFull, prevEmpty, prevDack, prevReq, prevEnd;

    assign errCount_o = errs;

    initial begin
        errs = 0;
        for (int i = 0; i < 8; i++) regValid[i] = 1'b0;
    end

    always @(posedge BCLK) begin
        if (!CRESET_) begin
            resetChecked = 1'b0;
            {rdRun, wrRun, dsackCount} = '0;
            occ = 0;
            {prevFull, prevEmpty, prevDack, prevReq, prevEnd} = 5'b01000;
        end else begin
            if (!resetChecked) begin
                resetChecked = 1'b1;
                if ({scsiCs_i, scsiRe_i, scsiWe_i, dack_i, dsack_i} != 5'b0) begin
                    errs++;
                    $display("[FAIL] {scsiCs_o,scsiRe_o,scsiWe_o,dack_o,dsack_o}: got %02h expected 00",
                             {scsiCs_i, scsiRe_i, scsiWe_i, dack_i, dsack_i});
                end
            end
            // Flags of the cycle just ended, before this cycle's updates
            expFull = (occ == Depth);
            expEmpty = (occ == 0);
            // A longword commit or release lands in the Ack cycle after the model counted it
            if (!dack_i) begin
                if (fifoFull_i != expFull) begin
                    errs++;
                    $display("[FAIL] fifoFull_o: got %01h expected %01h", fifoFull_i, expFull);
                end
                if (fifoEmpty_i != expEmpty) begin
                    errs++;
                    $display("[FAIL] fifoEmpty_o: got %01h expected %01h", fifoEmpty_i,
                             expEmpty);
                end
            end
            // CPU register accesses complete at dsack
            if (dsack_i) begin
                dsackCount++;
                if (!cpuRw_i) begin
                    regModel[chipAddr_i] = cpuData_i;
                    regValid[chipAddr_i] = 1'b1;
                end else if (!regValid[chipAddr_i]) begin
                    errs++;
                    $display("CPU read of chip register %0d that was never written", chipAddr_i);
                end else if (cpuDataOut_i != regModel[chipAddr_i]) begin
                    errs++;
                    $display("[FAIL] cpuData_o: got %02h expected %02h", cpuDataOut_i,
                             regModel[chipAddr_i]);
                end
            end
            if (prevReq && !cpuReq_i) begin
                if (dsackCount != 1) begin
                    errs++;
                    $display("CPU request ended after %0d dsack pulses instead of one", dsackCount);
                end
                dsackCount = 0;
            end
            // DMA read byte is the one on the bus in the last strobe cycle
            rdRun = (dack_i && scsiRe_i) ? rdRun + 1 : 0;
            if (rdRun == StrobeLen) begin
                inBytes.push_back(scsiData_i);
                if (inBytes.size() == 4) begin
                    word = {inBytes[0], inBytes[1], inBytes[2], inBytes[3]};
                    inWords.push_back(word);
                    inBytes.delete();
                    occ++;
                end
            end
            if (memPop_i && !expEmpty) begin
                occ--;
                if (inWords.size() == 0) begin
                    errs++;
                    $display("Longword popped with no DMA bytes read for it");
                end else begin
                    word = inWords.pop_front();
                    if (memDataOut_i != word) begin
                        errs++;
                        $display("[FAIL] memData_o: got %08h expected %08h", memDataOut_i, word);
                    end
                end
            end
            // Pushed longwords leave lane 0 first
            if (memPush_i && !expFull) begin
                for (int b = 3; b >= 0; b--) outBytes.push_back(memData_i[8 * b +: 8]);
                occ++;
            end
            wrRun = (dack_i && scsiWe_i) ? wrRun + 1 : 0;
            if (wrRun == 1) begin
                if (outBytes.size() == 0) begin
                    errs++;
                    $display("DMA write to the chip with no byte pending");
                end else begin
                    if (scsiDataOut_i != outBytes[0]) begin
                        errs++;
                        $display("[FAIL] scsiData_o: got %02h expected %02h", scsiDataOut_i,
                                 outBytes[0]);
                    end
                    void'(outBytes.pop_front());
                    // Last lane sent releases the head longword
                    if (outBytes.size() % 4 == 0) begin
                        occ--;
                    end
                end
            end
            // No DMA cycle may start against a full or empty FIFO
            if (dack_i && !prevDack && (dmaDir_i ? prevEmpty : prevFull)) begin
                errs++;
                $display("DMA cycle started while the FIFO could not take or give a byte");
            end
            if (endOfTest_i && !prevEnd) begin
                if (inBytes.size() != 0 || inWords.size() != 0 || outBytes.size() != 0) begin
                    errs++;
                    $display("Data left over at the end: %0d bytes in, %0d words, %0d bytes out",
                             inBytes.size(), inWords.size(), outBytes.size());
                end
            end
            prevReq = cpuReq_i;
            prevDack = dack_i;
            prevFull = expFull;
            prevEmpty = expEmpty;
            prevEnd = endOfTest_i;
        end
    end

endmodule

/* testbench/scsiDma_assertions.sv */
// Chip bus strobe rules, bound into every scsiSm instance
`include "scsiDma_config.svh"

module scsiDmaAssertions (
    input logic BCLK,
    input logic CRESET_,
    input logic scsiRe_i,
    input logic scsiWe_i,
    input logic scsiCs_i,
    input logic dack_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int StrobeLen = `SCSI_DMA_STROBE_CYCLES;

    int failCount = 0;
    logic [7:0] reLen;
    logic [7:0] weLen;

    // Length of the current strobe run
    always @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            reLen <= 8'd0;
            weLen <= 8'd0;
        end else begin
            reLen <= scsiRe_i ? reLen + 8'd1 : 8'd0;
            weLen <= scsiWe_i ? weLen + 8'd1 : 8'd0;
        end
    end

    rwApart: assert property (@(posedge BCLK) disable iff (!CRESET_) !(scsiRe_i && scsiWe_i))
        else begin failCount++; $error("RE and WE asserted together"); end

    csDackApart: assert property (@(posedge BCLK) disable iff (!CRESET_) !(scsiCs_i && dack_i))
        else begin failCount++; $error("CS and DACK asserted together"); end

    reWidth: assert property (@(posedge BCLK) disable iff (!CRESET_)
        $fell(scsiRe_i) |-> int'(reLen) == StrobeLen)
        else begin failCount++; $error("RE strobe width wrong"); end

    weWidth: assert property (@(posedge BCLK) disable iff (!CRESET_)
        $fell(scsiWe_i) |-> int'(weLen) == StrobeLen)
        else begin failCount++; $error("WE strobe width wrong"); end

endmodule

bind scsiSm scsiDmaAssertions u_strobeChecks (
    .BCLK(BCLK), .CRESET_(CRESET_), .scsiRe_i(scsiRe_o), .scsiWe_i(scsiWe_o),
    .scsiCs_i(scsiCs_o), .dack_i(dack_o)
);

/* verilog/scsiDmaTop.sv */
// SCSI DMA engine, chip sequencer plus longword FIFO
// dmaDir_i may only change while the FIFO is empty and on a longword boundary
`include "scsiDma_config.svh"

module scsiDmaTop (
    input  logic        BCLK,
    input  logic        CRESET_,
    // CPU register access
    input  logic        cpuReq_i,
    input  logic        cpuRw_i,
    input  logic [7:0]  cpuData_i,
    output logic [7:0]  cpuData_o,
    output logic        dsack_o,
    // SCSI chip bus
    input  logic        dreqN_i,
    input  logic [7:0]  scsiData_i,
    output logic        scsiCs_o,
    output logic        scsiRe_o,
    output logic        scsiWe_o,
    output logic        dack_o,
    output logic [7:0]  scsiData_o,
    // 0 is SCSI to FIFO
    input  logic        dmaDir_i,
    // Memory side of the FIFO
    input  logic        memPush_i,
    input  logic [31:0] memData_i,
    input  logic        memPop_i,
    output logic [31:0] memData_o,
    output logic        fifoFull_o,
    output logic        fifoEmpty_o
);

    // Sequencer to FIFO
    logic       incBo;
    logic       incNi;
    logic       incNo;
    logic [7:0] s2fByte;
    // FIFO to sequencer
    logic [7:0] f2sByte;
    logic       boEq3;

    scsiSm u_scsiSm (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .cpuReq_i    (cpuReq_i),
        .cpuRw_i     (cpuRw_i),
        .dmaDir_i    (dmaDir_i),
        .dreqN_i     (dreqN_i),
        .boEq3_i     (boEq3),
        .fifoFull_i  (fifoFull_o),
        .fifoEmpty_i (fifoEmpty_o),
        .scsiData_i  (scsiData_i),
        .cpuData_i   (cpuData_i),
        .f2sByte_i   (f2sByte),
        .scsiCs_o    (scsiCs_o),
        .scsiRe_o    (scsiRe_o),
        .scsiWe_o    (scsiWe_o),
        .dack_o      (dack_o),
        .scsiData_o  (scsiData_o),
        .cpuData_o   (cpuData_o),
        .s2fByte_o   (s2fByte),
        .dsack_o     (dsack_o),
        .incBo_o     (incBo),
        .incNi_o     (incNi),
        .incNo_o     (incNo)
    );

    dmaFifo #(
        .DepthLog2 (`SCSI_DMA_FIFO_DEPTH_LOG2)
    ) u_dmaFifo (
        .BCLK        (BCLK),
        .CRESET_     (CRESET_),
        .memPush_i   (memPush_i),
        .memData_i   (memData_i),
        .memPop_i    (memPop_i),
        .incBo_i     (incBo),
        .incNi_i     (incNi),
        .incNo_i     (incNo),
        .s2fByte_i   (s2fByte),
        .memData_o   (memData_o),
        .f2sByte_o   (f2sByte),
        .boEq3_o     (boEq3),
        .fifoFull_o  (fifoFull_o),
        .fifoEmpty_o (fifoEmpty_o)
    );

endmodule

/* verilog/dmaFifo.sv */
// Longword FIFO between the SCSI byte side and the memory side
// Memory push shares the write pointer with incNi_i, so only one of them
// may be active for a given DMA direction; full and empty drops are silent
`include "scsiDma_config.svh"

module dmaFifo #(
    parameter int DepthLog2 = `SCSI_DMA_FIFO_DEPTH_LOG2
) (
    input  logic        BCLK,
    input  logic        CRESET_,
    input  logic        memPush_i,
    input  logic [31:0] memData_i,
    input  logic        memPop_i,
    input  logic        incBo_i,
    input  logic        incNi_i,
    input  logic        incNo_i,
    input  logic [7:0]  s2fByte_i,
    output logic [31:0] memData_o,
    output logic [7:0]  f2sByte_o,
    output logic        boEq3_o,
    output logic        fifoFull_o,
    output logic        fifoEmpty_o
);

    localparam int Depth = 1 << DepthLog2;
    localparam logic [DepthLog2:0] DepthCnt = (DepthLog2 + 1)'(Depth);

    logic [31:0] mem [Depth];

    // Byte pointer, next-in and next-out pointers
    scsiDmaPkg::byteLane_t bytePtr;
    logic [DepthLog2-1:0]  niPtr;
    logic [DepthLog2-1:0]  noPtr;
    logic [DepthLog2:0]    count;

    // Partial longword gathered from the chip
    logic [31:0] asmReg;
    logic [31:0] asmNext;
    logic [31:0] headWord;

    logic push;
    logic commit;
    logic pop;
    logic release_;
    logic wrEn;
    logic rdEn;

    assign fifoFull_o  = (count == DepthCnt);
    assign fifoEmpty_o = (count == '0);

    assign push     = memPush_i && !fifoFull_o;
    assign commit   = incNi_i && !fifoFull_o;
    assign pop      = memPop_i && !fifoEmpty_o;
    assign release_ = incNo_i && !fifoEmpty_o;
    assign wrEn     = push || commit;
    assign rdEn     = pop || release_;

    // Merge the incoming byte at its big-endian lane
    always_comb begin
        asmNext = asmReg;
        asmNext[8 * (3 - int'(bytePtr)) +: 8] = s2fByte_i;
    end

    // Head entry feeds both the memory port and the chip byte path
    assign headWord  = mem[noPtr];
    assign memData_o = headWord;
    assign f2sByte_o = headWord[8 * (3 - int'(bytePtr)) +: 8];
    assign boEq3_o   = (bytePtr == 2'd3);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            bytePtr <= '0;
            niPtr   <= '0;
            noPtr   <= '0;
            count   <= '0;
        end else begin
            if (incBo_i) begin
                bytePtr <= bytePtr + 2'd1;
            end
            if (wrEn) begin
                niPtr <= niPtr + 1'b1;
            end
            if (rdEn) begin
                noPtr <= noPtr + 1'b1;
            end
            // Count follows accepted writes and reads
            case ({wrEn, rdEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Assembly register, only meaningful in the SCSI to FIFO direction
    always_ff @(posedge BCLK) begin
        if (incBo_i) begin
            asmReg <= asmNext;
        end
    end

    // Storage write, the last byte goes in together with the commit
    always_ff @(posedge BCLK) begin
        if (push) begin
            mem[niPtr] <= memData_i;
        end else if (commit) begin
            mem[niPtr] <= asmNext;
        end
    end

endmodule

/* verilog/scsiSm.sv */
// Sequencer for an 8-bit SCSI chip, one chip cycle in flight at a time
// cpuReq_i and dreqN_i are synchronized here, cpuRw_i and cpuData_i must
// stay stable while cpuReq_i is held, CPU wins over DMA at Idle
`include "scsiDma_config.svh"

module scsiSm (
    input  logic       BCLK,
    input  logic       CRESET_,
    input  logic       cpuReq_i,
    input  logic       cpuRw_i,
    input  logic       dmaDir_i,
    input  logic       dreqN_i,
    input  logic       boEq3_i,
    input  logic       fifoFull_i,
    input  logic       fifoEmpty_i,
    input  logic [7:0] scsiData_i,
    input  logic [7:0] cpuData_i,
    input  logic [7:0] f2sByte_i,
    output logic       scsiCs_o,
    output logic       scsiRe_o,
    output logic       scsiWe_o,
    output logic       dack_o,
    output logic [7:0] scsiData_o,
    output logic [7:0] cpuData_o,
    output logic [7:0] s2fByte_o,
    output logic       dsack_o,
    output logic       incBo_o,
    output logic       incNi_o,
    output logic       incNo_o
);

    localparam int StrobeLen  = `SCSI_DMA_STROBE_CYCLES;
    localparam int AckLen     = `SCSI_DMA_DSACK_DELAY;
    localparam int RecoverLen = `SCSI_DMA_RECOVER_CYCLES;

    // Two-flop synchronizers
    logic cpuReqMeta;
    logic cpuReqSync;
    logic dreqNMeta;
    logic dreqNSync;

    // Blocks the held request after its dsack until it drops
    logic cpuDone;

    scsiDmaPkg::smState_t state;
    scsiDmaPkg::smState_t nextState;
    logic [7:0] cycCnt;
    logic [7:0] cntNext;

    // Kind of the cycle in flight, fixed when leaving Idle
    logic cycCpu;
    logic cycRead;

    logic cpuPend;
    logic dmaPend;
    logic startCpu;
    logic startDma;
    logic kindCpuNext;
    logic kindReadNext;
    logic busNext;
    logic strobeNext;
    logic ackPulseNext;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuReqMeta <= 1'b0;
            cpuReqSync <= 1'b0;
            dreqNMeta  <= 1'b1;
            dreqNSync  <= 1'b1;
        end else begin
            cpuReqMeta <= cpuReq_i;
            cpuReqSync <= cpuReqMeta;
            dreqNMeta  <= dreqN_i;
            dreqNSync  <= dreqNMeta;
        end
    end

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            cpuDone <= 1'b0;
        end else if (dsack_o) begin
            cpuDone <= 1'b1;
        end else if (!cpuReqSync) begin
            cpuDone <= 1'b0;
        end
    end

    // Arbitration, DMA only when the FIFO can take or give a byte
    assign cpuPend  = cpuReqSync && !cpuDone;
    assign dmaPend  = !dreqNSync && (dmaDir_i ? !fifoEmpty_i : !fifoFull_i);
    assign startCpu = cpuPend;
    assign startDma = !cpuPend && dmaPend;

    // Cycle kind as it will be next cycle
    // DMA reads the chip when moving SCSI to FIFO
    assign kindCpuNext  = (state == scsiDmaPkg::Idle) ? startCpu : cycCpu;
    assign kindReadNext = (state == scsiDmaPkg::Idle) ?
                          (startCpu ? cpuRw_i : !dmaDir_i) : cycRead;

    always_comb begin
        nextState = state;
        cntNext   = cycCnt + 8'd1;
        case (state)
            scsiDmaPkg::Idle: begin
                if (startCpu || startDma) begin
                    nextState = scsiDmaPkg::Setup;
                end
            end
            scsiDmaPkg::Setup: begin
                // Single strobe cycle goes straight to Latch
                nextState = (StrobeLen > 1) ? scsiDmaPkg::Strobe : scsiDmaPkg::Latch;
            end
            scsiDmaPkg::Strobe: begin
                if (int'(cycCnt) >= StrobeLen - 2) begin
                    nextState = scsiDmaPkg::Latch;
                end
            end
            scsiDmaPkg::Latch: begin
                nextState = scsiDmaPkg::Ack;
            end
            scsiDmaPkg::Ack: begin
                if (int'(cycCnt) >= AckLen - 1) begin
                    nextState = (RecoverLen > 0) ? scsiDmaPkg::Recover : scsiDmaPkg::Idle;
                end
            end
            scsiDmaPkg::Recover: begin
                if (int'(cycCnt) >= RecoverLen - 1) begin
                    nextState = scsiDmaPkg::Idle;
                end
            end
            default: begin
                nextState = scsiDmaPkg::Idle;
            end
        endcase
        // Counter restarts on every state change
        if (nextState != state) begin
            cntNext = 8'd0;
        end
    end

    // Output levels of the coming cycle
    assign busNext      = (nextState == scsiDmaPkg::Setup) || (nextState == scsiDmaPkg::Strobe) ||
                          (nextState == scsiDmaPkg::Latch) || (nextState == scsiDmaPkg::Ack);
    assign strobeNext   = (nextState == scsiDmaPkg::Strobe) || (nextState == scsiDmaPkg::Latch);
    assign ackPulseNext = (nextState == scsiDmaPkg::Ack) && (int'(cntNext) == AckLen - 1);

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            state   <= scsiDmaPkg::Idle;
            cycCnt  <= 8'd0;
            cycCpu  <= 1'b0;
            cycRead <= 1'b0;
        end else begin
            state   <= nextState;
            cycCnt  <= cntNext;
            cycCpu  <= kindCpuNext;
            cycRead <= kindReadNext;
        end
    end

    // Registered chip strobes and handshake pulses
    // boEq3_i only moves on incBo_o so it is stable through Ack
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (!CRESET_) begin
            scsiCs_o <= 1'b0;
            dack_o   <= 1'b0;
            scsiRe_o <= 1'b0;
            scsiWe_o <= 1'b0;
            dsack_o  <= 1'b0;
            incBo_o  <= 1'b0;
            incNi_o  <= 1'b0;
            incNo_o  <= 1'b0;
        end else begin
            scsiCs_o <= busNext && kindCpuNext;
            dack_o   <= busNext && !kindCpuNext;
            scsiRe_o <= strobeNext && kindReadNext;
            scsiWe_o <= strobeNext && !kindReadNext;
            dsack_o  <= ackPulseNext && kindCpuNext;
            incBo_o  <= ackPulseNext && !kindCpuNext;
            // Longword boundary commits or releases an entry
            incNi_o  <= ackPulseNext && !kindCpuNext && kindReadNext && boEq3_i;
            incNo_o  <= ackPulseNext && !kindCpuNext && !kindReadNext && boEq3_i;
        end
    end

    // Write data taken at cycle start, CPU register or FIFO byte
    always_ff @(posedge BCLK) begin
        if (state == scsiDmaPkg::Idle && nextState == scsiDmaPkg::Setup) begin
            scsiData_o <= startCpu ? cpuData_i : f2sByte_i;
        end
    end

    // Read data sampled at the end of the last strobe cycle
    always_ff @(posedge BCLK) begin
        if (state == scsiDmaPkg::Latch && cycRead) begin
            if (cycCpu) begin
                cpuData_o <= scsiData_i;
            end else begin
                s2fByte_o <= scsiData_i;
            end
        end
    end

endmodule

/* verilog/scsiDmaPkg.sv */
// Shared types of the SCSI DMA engine
// Byte lanes are big-endian, lane 0 is bits 31:24 of a longword
package scsiDmaPkg;

    // Chip cycle sequencer states
    // Idle     arbitration between CPU and DMA, chip bus released
    // Setup    CS or DACK asserted, no strobe yet
    // Strobe   RE or WE asserted, all but the last strobe cycle
    // Latch    last strobe cycle, read data captured at its end
    // Ack      CS or DACK still held, dsack or FIFO increments pulse
    // Recover  chip bus idle before the next arbitration
    typedef enum logic [2:0] {
        Idle    = 3'd0,
        Setup   = 3'd1,
        Strobe  = 3'd2,
        Latch   = 3'd3,
        Ack     = 3'd4,
        Recover = 3'd5
    } smState_t;

    // Byte pointer inside a longword
    // Wraps from 3 back to 0 on the next increment
    typedef logic [1:0] byteLane_t;

endpackage

/* verilog/scsiDma_config.svh */
// Build-time sizing for the SCSI DMA engine, all counts in BCLK cycles
// Strobe, dsack delay and recovery counts must be at least 1 and below 256
`ifndef SCSI_DMA_CONFIG_SVH
`define SCSI_DMA_CONFIG_SVH

// Log2 of the number of longword entries in the DMA FIFO
`define SCSI_DMA_FIFO_DEPTH_LOG2 3

// Read or write strobe width seen by the SCSI chip
`define SCSI_DMA_STROBE_CYCLES 2

// Idle gap on the chip bus after every chip cycle
`define SCSI_DMA_RECOVER_CYCLES 1

// Cycles from strobe end to the dsack or increment pulse
// 1 puts the pulse in the cycle right after the strobe
`define SCSI_DMA_DSACK_DELAY 1

`endif
